//--- Bender.yml
package:
  name: ct_fcnvt_htos

sources:
  # RTL in compile order
  - files:
      - verilog/ct_fcnvt_htos_pkg.sv
      - verilog/ct_fcnvt_htos_sh.sv
      - verilog/ct_fcnvt_htos_issue_q.sv
      - verilog/ct_fcnvt_htos_norm.sv
      - verilog/ct_fcnvt_htos_pack.sv
      - verilog/ct_fcnvt_htos_top.sv

  # Verification sources
  - target: test
    files:
      - verif/ct_fcnvt_htos_assert.sv
      - verif/ct_fcnvt_htos_tb.sv

//--- all.f
verilog/ct_fcnvt_htos_pkg.sv
verilog/ct_fcnvt_htos_sh.sv
verilog/ct_fcnvt_htos_issue_q.sv
verilog/ct_fcnvt_htos_norm.sv
verilog/ct_fcnvt_htos_pack.sv
verilog/ct_fcnvt_htos_top.sv
verif/ct_fcnvt_htos_assert.sv
verif/ct_fcnvt_htos_tb.sv

//--- verif/ct_fcnvt_htos_assert.sv
////////////////////////////////////////////////////////////////////////////
// Credit protocol assertions for the half to single converter top
// Tracks credits on both sides and checks result bits while valid
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ct_fcnvt_htos_assert (
  input logic        forever_cpuclk,
  input logic        rst_n,
  input logic        in_valid,
  input logic        in_credit,
  input logic        out_valid,
  input logic        out_credit,
  input logic [31:0] out_result
);

  import ct_fcnvt_htos_pkg::*;

  // Accepted inputs not yet credited back, results not yet credited
  int in_held;
  int out_held;

  // Failed assertions so far
  int num_fails = 0;

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      in_held  <= 0;
      out_held <= 0;
    end else begin
      in_held  <= in_held + int'(in_valid) - int'(in_credit);
      out_held <= out_held + int'(out_valid) - int'(out_credit);
    end
  end

  // A new result needs a free consumer credit
  a_out_credit: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    out_valid |-> out_held < OUT_CREDITS)
    else begin
      num_fails++;
      $error("result sent without a consumer credit");
    end

  a_in_credit: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    in_credit |-> in_held > 0)
    else begin
      num_fails++;
      $error("in_credit with no accepted input left");
    end

  a_result_known: assert property (@(posedge forever_cpuclk) disable iff (!rst_n)
    out_valid |-> !$isunknown(out_result))
    else begin
      num_fails++;
      $error("unknown bits in out_result");
    end

endmodule

bind ct_fcnvt_htos_top ct_fcnvt_htos_assert i_assert (
  .forever_cpuclk (forever_cpuclk),
  .rst_n          (rst_n),
  .in_valid       (in_valid),
  .in_credit      (in_credit),
  .out_valid      (out_valid),
  .out_credit     (out_credit),
  .out_result     (out_result)
);

//--- verif/ct_fcnvt_htos_tb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the half to single converter
// Replays the stimulus vectors under credit flow control on both sides
// and checks results, invalid flags and credit counts in arrival order
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ct_fcnvt_htos_tb;

  import ct_fcnvt_htos_pkg::*;

  // Cycles any single wait may take
  localparam int WAIT_LIMIT = 500;

  logic        forever_cpuclk;
  logic        rst_n;
  logic        in_valid;
  logic [15:0] in_half;
  logic        out_credit;
  logic        in_credit;
  logic        out_valid;
  logic [31:0] out_result;
  logic        out_nv;

  // Vectors from the stimulus file
  logic [15:0] half_q [$];
  logic [31:0] exp_q [$];
  logic        nv_q [$];

  logic [15:0] lfsr = 16'd1163;
  int          num_tests;
  int          sent_cnt;
  int          rx_cnt;
  int          crd_seen;
  int          crd_back;
  int          pass_cnt;
  int          fail_cnt;
  int          err_cnt;
  bit          hung;

  ct_fcnvt_htos_top i_dut (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_half        (in_half),
    .out_credit     (out_credit),
    .in_credit      (in_credit),
    .out_valid      (out_valid),
    .out_result     (out_result),
    .out_nv         (out_nv)
  );

  // 8 ns clock
  initial begin
    forever_cpuclk = 1'b0;
    forever begin
      #4 forever_cpuclk = ~forever_cpuclk;
    end
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual, output bit ok);
    ok = (actual === expected);
    if (!ok) begin
      $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
  endtask

  task automatic finish_test(input string name, input bit ok);
    if (ok) begin
      $display("PASS %s", name);
      pass_cnt++;
    end else begin
      $display("FAIL %s", name);
      fail_cnt++;
    end
  endtask

  task automatic report_hang(input string what);
    $display("Timeout while waiting for %s", what);
    err_cnt++;
    hung = 1'b1;
  endtask

  // Comment lines start with #
  task automatic load_stimulus();
    int          fd;
    int          code;
    string       line;
    logic [15:0] h;
    logic [31:0] r;
    logic [3:0]  f;
    fd = $fopen("verif/htos_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file");
      err_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code > 0 && line[0] != "#" && $sscanf(line, "%h %h %h", h, r, f) == 3) begin
        half_q.push_back(h);
        exp_q.push_back(r);
        nv_q.push_back(f[0]);
      end
    end
    $fclose(fd);
    num_tests = half_q.size();
    if (num_tests == 0) begin
      $display("No vectors found in the stimulus file");
      err_cnt++;
    end
  endtask

  // Upstream producer that sends only while holding a credit
  task automatic send_all();
    int waited;
    for (int i = 0; i < num_tests && !hung; i++) begin
      waited = 0;
      while (IN_DEPTH + crd_seen - sent_cnt <= 0 && waited < WAIT_LIMIT) begin
        in_valid = 1'b0;
        @(posedge forever_cpuclk);
        #1;
        waited++;
      end
      if (IN_DEPTH + crd_seen - sent_cnt <= 0) begin
        report_hang("an upstream credit");
        break;
      end
      in_valid = 1'b1;
      in_half  = half_q[i];
      sent_cnt++;
      @(posedge forever_cpuclk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  // Consumer returns one credit per result after 0 to 7 cycles
  task automatic return_credits();
    int waited;
    int delay;
    for (int k = 0; k < num_tests && !hung; k++) begin
      waited = 0;
      while (rx_cnt <= k && !hung && waited < WAIT_LIMIT) begin
        @(posedge forever_cpuclk);
        waited++;
      end
      if (rx_cnt <= k) begin
        if (!hung) begin
          report_hang("a result to return a credit for");
        end
        break;
      end
      delay = 0;
      for (int b = 0; b < 3; b++) begin
        lfsr  = lfsr_step(lfsr);
        delay = (delay << 1) | lfsr[0];
      end
      repeat (delay + 1) @(posedge forever_cpuclk);
      #1 out_credit = 1'b1;
      crd_back++;
      @(posedge forever_cpuclk);
      #1 out_credit = 1'b0;
    end
  endtask

  task automatic receive_result();
    bit    ok_res;
    bit    ok_nv;
    string name;
    if (rx_cnt >= num_tests) begin
      $display("Unexpected result 0x%08h after the last vector", out_result);
      err_cnt++;
    end else begin
      name = $sformatf("vector %0d half 0x%04h", rx_cnt, half_q[rx_cnt]);
      check_value({name, " result"}, exp_q[rx_cnt], out_result, ok_res);
      check_value({name, " invalid flag"}, 32'(nv_q[rx_cnt]), 32'(out_nv), ok_nv);
      finish_test(name, ok_res && ok_nv);
      rx_cnt++;
      if (rx_cnt - crd_back > OUT_CREDITS) begin
        $display("More results outstanding than the consumer has credits");
        err_cnt++;
      end
    end
  endtask

  // Outputs sampled mid-cycle
  always @(negedge forever_cpuclk) begin
    if (rst_n) begin
      if (in_credit) begin
        crd_seen++;
        if (crd_seen > sent_cnt) begin
          $display("in_credit pulse without a matching input");
          err_cnt++;
        end
      end
      if (out_valid) begin
        receive_result();
      end
    end
  end

  initial begin : main
    bit ok;
    bit idle_ok;
    int waited;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_half    = '0;
    out_credit = 1'b0;
    load_stimulus();
    repeat (8) @(posedge forever_cpuclk);
    #1 rst_n = 1'b1;
    // Quiet until the first input
    idle_ok = 1'b1;
    repeat (4) begin
      @(negedge forever_cpuclk);
      check_value("idle in_credit", 32'd0, 32'(in_credit), ok);
      idle_ok &= ok;
      check_value("idle out_valid", 32'd0, 32'(out_valid), ok);
      idle_ok &= ok;
    end
    finish_test("outputs idle after reset", idle_ok);
    @(posedge forever_cpuclk);
    #1;
    fork
      send_all();
      return_credits();
    join_none
    waited = 0;
    while (rx_cnt < num_tests && !hung && waited < WAIT_LIMIT) begin
      @(posedge forever_cpuclk);
      waited++;
    end
    if (rx_cnt < num_tests && !hung) begin
      report_hang("all results");
    end
    // Room for a stray extra result
    repeat (10) @(posedge forever_cpuclk);
    check_value("in_credit pulse count", num_tests, crd_seen, ok);
    finish_test("one in_credit pulse per input", ok);
    err_cnt += i_dut.i_assert.num_fails;
    $display("Summary: %0d passed, %0d failed, %0d other errors", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0 && !hung) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- verif/htos_stimulus.txt
# half input (hex), expected single result (hex), expected invalid flag
# normals, subnormals bit 9 down to 0, zeros, infinities, quiet and signaling NaNs
3c00 3f800000 0
c000 c0000000 0
7bff 477fe000 0
0400 38800000 0
3555 3eaaa000 0
0200 38000000 0
8155 b7aa8000 0
00ff 377f0000 0
0041 36820000 0
0020 36000000 0
001b 35d80000 0
800a b5200000 0
0007 34e00000 0
0003 34400000 0
0001 33800000 0
0000 00000000 0
8000 80000000 0
7c00 7f800000 0
fc00 ff800000 0
7e00 7fc00000 0
7e55 7fcaa000 0
7c01 7fc02000 1
fd55 ffeaa000 1

//--- verilog/ct_fcnvt_htos_issue_q.sv
////////////////////////////////////////////////////////////////////////////
// Issue queue for the half to single converter
// Buffers incoming halves and returns one upstream credit per pop.
// Issue is gated by the credits held toward the consumer.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ct_fcnvt_htos_issue_q (
  input  logic                                 forever_cpuclk,
  input  logic                                 rst_n,
  input  logic                                 in_valid,
  input  logic [ct_fcnvt_htos_pkg::HALF_W-1:0] in_half,
  input  logic                                 out_credit,
  output logic                                 in_credit,
  output logic                                 issue_valid,
  output logic [ct_fcnvt_htos_pkg::HALF_W-1:0] issue_half
);

  import ct_fcnvt_htos_pkg::*;

  logic [HALF_W-1:0] buf_mem [IN_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  occ_cnt;
  logic [CNT_W-1:0]  crd_cnt;
  logic              buf_pop;

  // Pop needs an entry and a downstream credit
  assign buf_pop = (occ_cnt != '0) && (crd_cnt != '0);

  // Head goes straight to the norm stage
  assign issue_valid = buf_pop;
  assign issue_half  = buf_mem[rd_ptr];

  // Freed slot goes back upstream in the pop cycle
  assign in_credit = buf_pop;

  // Storage, no reset needed
  always_ff @(posedge forever_cpuclk) begin
    if (in_valid) begin
      buf_mem[wr_ptr] <= in_half;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (buf_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy, push and pop may coincide
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      occ_cnt <= '0;
    end else begin
      case ({in_valid, buf_pop})
        2'b10:   occ_cnt <= occ_cnt + 1'b1;
        2'b01:   occ_cnt <= occ_cnt - 1'b1;
        default: occ_cnt <= occ_cnt;
      endcase
    end
  end

  // Downstream credits
  // Spent on issue, returned by an out_credit pulse
  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      crd_cnt <= CNT_W'(OUT_CREDITS);
    end else begin
      case ({buf_pop, out_credit})
        2'b10:   crd_cnt <= crd_cnt - 1'b1;
        2'b01:   crd_cnt <= crd_cnt + 1'b1;
        default: crd_cnt <= crd_cnt;
      endcase
    end
  end

endmodule

//--- verilog/ct_fcnvt_htos_norm.sv
////////////////////////////////////////////////////////////////////////////
// Norm stage of the half to single converter
// Classifies the half operand, normalizes subnormals through the
// leading-one shifter and forms the biased single exponent
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ct_fcnvt_htos_norm (
  input  logic                                        forever_cpuclk,
  input  logic                                        rst_n,
  input  logic                                        issue_valid,
  input  logic [ct_fcnvt_htos_pkg::HALF_W-1:0]        issue_half,
  output logic                                        norm_valid,
  output logic                                        norm_sign,
  output logic [ct_fcnvt_htos_pkg::SINGLE_EXP_W-1:0]  norm_exp,
  output logic [ct_fcnvt_htos_pkg::HALF_FRAC_W-1:0]   norm_frac,
  output ct_fcnvt_htos_pkg::htos_class_t              norm_class
);

  import ct_fcnvt_htos_pkg::*;

  logic [HALF_EXP_W-1:0]   half_exp;
  logic [HALF_FRAC_W-1:0]  half_frac;
  logic [SH_CNT_W-1:0]     sh_cnt;
  logic [HALF_FRAC_W:0]    sh_f_v;
  htos_class_t             cls_nxt;
  logic [SINGLE_EXP_W-1:0] exp_nxt;
  logic [HALF_FRAC_W-1:0]  frac_nxt;

  assign half_exp  = issue_half[HALF_W-2 -: HALF_EXP_W];
  assign half_frac = issue_half[HALF_FRAC_W-1:0];

  // Leading-one search for subnormal inputs
  ct_fcnvt_htos_sh i_sh (
    .htos_sh_src (half_frac),
    .htos_sh_cnt (sh_cnt),
    .htos_sh_f_v (sh_f_v)
  );

  // Class from exponent field and fraction
  always_comb begin
    if (half_exp == '0) begin
      cls_nxt = (half_frac == '0) ? HTOS_ZERO : HTOS_SUB;
    end else if (half_exp == HALF_EXP_MAX) begin
      if (half_frac == '0) begin
        cls_nxt = HTOS_INF;
      end else if (half_frac[HALF_FRAC_W-1]) begin
        cls_nxt = HTOS_QNAN;
      end else begin
        // Top fraction bit clear, payload non-zero
        cls_nxt = HTOS_SNAN;
      end
    end else begin
      cls_nxt = HTOS_NORM;
    end
  end

  // Exponent and fraction per class
  always_comb begin
    case (cls_nxt)
      HTOS_ZERO: begin
        exp_nxt  = '0;
        frac_nxt = '0;
      end
      HTOS_SUB: begin
        // Hidden one dropped, bit 10 of the shifted value
        exp_nxt  = {2'b00, sh_cnt} + SUB_EXP_ADJ;
        frac_nxt = sh_f_v[HALF_FRAC_W-1:0];
      end
      HTOS_NORM: begin
        exp_nxt  = {3'b000, half_exp} + NORM_EXP_ADJ;
        frac_nxt = half_frac;
      end
      default: begin
        // Infinity and both NaNs keep the payload
        exp_nxt  = SINGLE_EXP_MAX;
        frac_nxt = half_frac;
      end
    endcase
  end

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      norm_valid <= 1'b0;
    end else begin
      norm_valid <= issue_valid;
    end
  end

  // Payload follows valid, no reset
  always_ff @(posedge forever_cpuclk) begin
    if (issue_valid) begin
      norm_sign  <= issue_half[HALF_W-1];
      norm_exp   <= exp_nxt;
      norm_frac  <= frac_nxt;
      norm_class <= cls_nxt;
    end
  end

endmodule

//--- verilog/ct_fcnvt_htos_pack.sv
////////////////////////////////////////////////////////////////////////////
// Pack stage of the half to single converter
// Quiets signaling NaNs, builds the single result and raises invalid
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ct_fcnvt_htos_pack (
  input  logic                                       forever_cpuclk,
  input  logic                                       rst_n,
  input  logic                                       norm_valid,
  input  logic                                       norm_sign,
  input  logic [ct_fcnvt_htos_pkg::SINGLE_EXP_W-1:0] norm_exp,
  input  logic [ct_fcnvt_htos_pkg::HALF_FRAC_W-1:0]  norm_frac,
  input  ct_fcnvt_htos_pkg::htos_class_t             norm_class,
  output logic                                       out_valid,
  output logic [ct_fcnvt_htos_pkg::SINGLE_W-1:0]     out_result,
  output logic                                       out_nv
);

  import ct_fcnvt_htos_pkg::*;

  logic [HALF_FRAC_W-1:0]   frac_q;
  logic [SINGLE_FRAC_W-1:0] single_frac;
  logic                     nv_nxt;

  // Signaling NaN gets its quiet bit and flags invalid
  assign nv_nxt = (norm_class == HTOS_SNAN);
  assign frac_q = nv_nxt ? (norm_frac | {1'b1, {(HALF_FRAC_W-1){1'b0}}}) : norm_frac;

  // Widening is exact, low 13 bits always zero
  assign single_frac = {frac_q, {(SINGLE_FRAC_W-HALF_FRAC_W){1'b0}}};

  always_ff @(posedge forever_cpuclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= norm_valid;
    end
  end

  // Sign passes through for every class
  always_ff @(posedge forever_cpuclk) begin
    if (norm_valid) begin
      out_result <= {norm_sign, norm_exp, single_frac};
      out_nv     <= nv_nxt;
    end
  end

endmodule

//--- verilog/ct_fcnvt_htos_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Half to single conversion package
// Format widths, exponent adjust constants, buffer and credit sizes,
// and the operand class passed between the pipeline stages
////////////////////////////////////////////////////////////////////////////

package ct_fcnvt_htos_pkg;

  // Operand and result widths
  localparam int HALF_W        = 16;
  localparam int SINGLE_W      = 32;
  localparam int HALF_FRAC_W   = 10;
  localparam int HALF_EXP_W    = 5;
  localparam int SINGLE_EXP_W  = 8;
  localparam int SINGLE_FRAC_W = 23;

  // Leading-one shifter exponent code
  localparam int SH_CNT_W = 6;

  // Half exponent field of all ones marks infinity or NaN
  localparam logic [HALF_EXP_W-1:0] HALF_EXP_MAX = '1;

  // Single exponent for infinity and NaN
  localparam logic [SINGLE_EXP_W-1:0] SINGLE_EXP_MAX = '1;

  // Shifter code 0x31 -> 112, code 0x28 -> 103
  localparam logic [SINGLE_EXP_W-1:0] SUB_EXP_ADJ = 8'd63;

  // Bias 127 minus bias 15
  localparam logic [SINGLE_EXP_W-1:0] NORM_EXP_ADJ = 8'd112;

  // Input buffer size, also the upstream credit count at reset
  localparam int IN_DEPTH = 4;
  localparam int PTR_W    = $clog2(IN_DEPTH);

  // Credits held toward the consumer after reset
  localparam int OUT_CREDITS = 4;

  // Credit and occupancy counters, wide enough for 0..4
  localparam int CNT_W = 3;

  // Operand class, decided in the norm stage
  typedef enum logic [2:0] {
    HTOS_ZERO = 3'd0,
    HTOS_SUB  = 3'd1,
    HTOS_NORM = 3'd2,
    HTOS_INF  = 3'd3,
    HTOS_QNAN = 3'd4,
    HTOS_SNAN = 3'd5
  } htos_class_t;

endpackage

//--- verilog/ct_fcnvt_htos_sh.sv
////////////////////////////////////////////////////////////////////////////
// Leading-one shifter for half subnormal fractions
// Aligns the first set bit to the top and returns the exponent code,
// 0x31 for bit 9 down to 0x28 for bit 0, zero for a zero fraction
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ct_fcnvt_htos_sh (
  input  logic [ct_fcnvt_htos_pkg::HALF_FRAC_W-1:0] htos_sh_src,
  output logic [ct_fcnvt_htos_pkg::SH_CNT_W-1:0]    htos_sh_cnt,
  output logic [ct_fcnvt_htos_pkg::HALF_FRAC_W:0]   htos_sh_f_v
);

  import ct_fcnvt_htos_pkg::*;

  // Priority on the leading one
  // Bit 10 of the result holds the hidden one
  always_comb begin
    casez (htos_sh_src)
      10'b1?????????: begin
        htos_sh_f_v = {htos_sh_src, 1'b0};
        htos_sh_cnt = 6'h31;
      end
      10'b01????????: begin
        htos_sh_f_v = {htos_sh_src[8:0], 2'b0};
        htos_sh_cnt = 6'h30;
      end
      10'b001???????: begin
        htos_sh_f_v = {htos_sh_src[7:0], 3'b0};
        htos_sh_cnt = 6'h2f;
      end
      10'b0001??????: begin
        htos_sh_f_v = {htos_sh_src[6:0], 4'b0};
        htos_sh_cnt = 6'h2e;
      end
      10'b00001?????: begin
        htos_sh_f_v = {htos_sh_src[5:0], 5'b0};
        htos_sh_cnt = 6'h2d;
      end
      10'b000001????: begin
        htos_sh_f_v = {htos_sh_src[4:0], 6'b0};
        htos_sh_cnt = 6'h2c;
      end
      10'b0000001???: begin
        htos_sh_f_v = {htos_sh_src[3:0], 7'b0};
        htos_sh_cnt = 6'h2b;
      end
      10'b00000001??: begin
        htos_sh_f_v = {htos_sh_src[2:0], 8'b0};
        htos_sh_cnt = 6'h2a;
      end
      10'b000000001?: begin
        htos_sh_f_v = {htos_sh_src[1:0], 9'b0};
        htos_sh_cnt = 6'h29;
      end
      10'b0000000001: begin
        htos_sh_f_v = {htos_sh_src[0], 10'b0};
        // Smallest subnormal, 2^-24
        htos_sh_cnt = 6'h28;
      end
      default: begin
        // No leading one at all
        htos_sh_f_v = '0;
        htos_sh_cnt = '0;
      end
    endcase
  end

endmodule

//--- verilog/ct_fcnvt_htos_top.sv
////////////////////////////////////////////////////////////////////////////
// Half to single conversion top level
// Credit-controlled issue queue followed by the norm and pack stages
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ct_fcnvt_htos_top (
  input  logic                                   forever_cpuclk,
  input  logic                                   rst_n,
  input  logic                                   in_valid,
  input  logic [ct_fcnvt_htos_pkg::HALF_W-1:0]   in_half,
  input  logic                                   out_credit,
  output logic                                   in_credit,
  output logic                                   out_valid,
  output logic [ct_fcnvt_htos_pkg::SINGLE_W-1:0] out_result,
  output logic                                   out_nv
);

  import ct_fcnvt_htos_pkg::*;

  logic                    issue_valid;
  logic [HALF_W-1:0]       issue_half;
  logic                    norm_valid;
  logic                    norm_sign;
  logic [SINGLE_EXP_W-1:0] norm_exp;
  logic [HALF_FRAC_W-1:0]  norm_frac;
  htos_class_t             norm_class;

  // Buffer and downstream credit gate
  ct_fcnvt_htos_issue_q i_issue_q (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_half        (in_half),
    .out_credit     (out_credit),
    .in_credit      (in_credit),
    .issue_valid    (issue_valid),
    .issue_half     (issue_half)
  );

  ct_fcnvt_htos_norm i_norm (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .issue_valid    (issue_valid),
    .issue_half     (issue_half),
    .norm_valid     (norm_valid),
    .norm_sign      (norm_sign),
    .norm_exp       (norm_exp),
    .norm_frac      (norm_frac),
    .norm_class     (norm_class)
  );

  // Result two cycles after issue
  ct_fcnvt_htos_pack i_pack (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .norm_valid     (norm_valid),
    .norm_sign      (norm_sign),
    .norm_exp       (norm_exp),
    .norm_frac      (norm_frac),
    .norm_class     (norm_class),
    .out_valid      (out_valid),
    .out_result     (out_result),
    .out_nv         (out_nv)
  );

endmodule
